/* common/bridge_pkg.sv */
package bridge_pkg;

   // ********************
   // Bus widths
   // ********************
   localparam int ADDR_W = 32;              // AHB and AXI address
   localparam int DATA_W = 64;              // Data bus, one dword
   localparam int STRB_W = DATA_W / 8;      // One strobe per byte lane

   // ********************
   // AHB encodings
   // ********************
   // HTRANS, SEQ is never issued by the master
   localparam logic [1:0] HTRANS_IDLE   = 2'b00;
   localparam logic [1:0] HTRANS_BUSY   = 2'b01;
   localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

   // HSIZE, also reused as AXI size
   localparam logic [2:0] HSIZE_BYTE  = 3'b000;
   localparam logic [2:0] HSIZE_HALF  = 3'b001;
   localparam logic [2:0] HSIZE_WORD  = 3'b010;
   localparam logic [2:0] HSIZE_DWORD = 3'b011;

   // ********************
   // Bus FSM states
   // ********************
   typedef enum logic [1:0] {
      IDLE = 2'b00,                         // No transfer in data phase
      WR   = 2'b01,                         // Write data phase
      RD   = 2'b10,                         // Read data phase, command going out
      PEND = 2'b11                          // Read on AXI, waiting for R
   } bus_state_t;

   // ********************
   // Captured address phase
   // ********************
   typedef struct packed {
      logic              write;             // HWRITE of the transfer
      logic [2:0]        size;              // HSIZE of the transfer
      logic [ADDR_W-1:0] addr;              // HADDR of the transfer
   } ahb_req_t;

   // Byte offset bits inside one data word
   localparam int OFFS_W = $clog2(STRB_W);

endpackage

/* ahb_slave/ahb_addr_phase.sv */
`timescale 1ns/1ps

module ahb_addr_phase import bridge_pkg::*; #(
   parameter logic [ADDR_W-1:0] DCCM_BASE,
   parameter int                DCCM_SIZE_KB,
   parameter bit                ICCM_EN,
   parameter logic [ADDR_W-1:0] ICCM_BASE,
   parameter int                ICCM_SIZE_KB
) (
   input  logic              ahb_clk,
   input  logic              rst,
   input  logic [ADDR_W-1:0] haddr,
   input  logic [1:0]        htrans,
   input  logic [2:0]        hsize,
   input  logic              hwrite,
   input  logic              hsel,
   input  logic              addr_capture,   // Address phase accepted this cycle
   output ahb_req_t          req,            // Registered address phase
   output logic              access_err      // Registered transfer breaks a rule
);

   // Window masks, sizes are powers of two and bases aligned to them
   localparam logic [ADDR_W-1:0] DCCM_MASK = ~(ADDR_W'(DCCM_SIZE_KB) * 1024 - 1);
   localparam logic [ADDR_W-1:0] ICCM_MASK = ~(ADDR_W'(ICCM_SIZE_KB) * 1024 - 1);

   logic [1:0] htrans_q;                     // HTRANS seen by this slave
   logic       trans_act;
   logic       in_dccm;
   logic       in_iccm;
   logic       size_ok;                      // Word or dword
   logic       unmapped;
   logic       bad_size;
   logic       misaligned;

   // ********************
   // Address phase registers
   // ********************
   // Transfer type follows the bus every cycle, masked when not selected
   always_ff @(posedge ahb_clk) begin
      if (rst) begin
         htrans_q <= HTRANS_IDLE;
      end else begin
         htrans_q <= hsel ? htrans : HTRANS_IDLE;
      end
   end

   // Address, size and direction only on an accepted address phase
   always_ff @(posedge ahb_clk) begin
      if (addr_capture) begin
         req.write <= hwrite;
         req.size  <= hsize;
         req.addr  <= haddr;
      end
   end

   // ********************
   // Window decode
   // ********************
   assign in_dccm = (req.addr & DCCM_MASK) == (DCCM_BASE & DCCM_MASK);
   assign in_iccm = ICCM_EN && ((req.addr & ICCM_MASK) == (ICCM_BASE & ICCM_MASK));

   // ********************
   // Access rules
   // ********************
   assign trans_act = (htrans_q != HTRANS_IDLE);
   assign size_ok   = (req.size == HSIZE_WORD) | (req.size == HSIZE_DWORD);

   assign unmapped = ~(in_dccm | in_iccm);   // Neither window hit

   // ICCM takes only word/dword, DCCM writes likewise
   assign bad_size = (in_iccm | (in_dccm & req.write)) & ~size_ok;

   // Natural alignment per size
   always_comb begin
      misaligned = 1'b0;
      case (req.size)
         HSIZE_HALF:  misaligned = req.addr[0];
         HSIZE_WORD:  misaligned = |req.addr[1:0];
         HSIZE_DWORD: misaligned = |req.addr[2:0];
         default:     misaligned = 1'b0;   // Bytes always aligned
      endcase
   end

   // Qualified by the bus state in the FSM
   assign access_err = trans_act & (unmapped | bad_size | misaligned);

endmodule

/* ahb_slave/ahb_bus_fsm.sv */
`timescale 1ns/1ps

module ahb_bus_fsm import bridge_pkg::*; (
   input  logic              ahb_clk,
   input  logic              rst,
   input  logic [1:0]        htrans,
   input  logic              hwrite,
   input  logic              hsel,
   input  logic              hreadyin,
   input  logic              access_err,     // From address phase check
   input  logic              cmd_full,       // Command buffer still waiting
   input  logic              cmd_write,      // Buffered command is a write
   input  logic              rvalid,
   input  logic [DATA_W-1:0] rdata,
   input  logic [1:0]        rresp,
   output logic              hready,         // Bus level HREADY
   output logic              addr_capture,
   output logic              cmd_load,
   output logic [DATA_W-1:0] hrdata,
   output logic              hreadyout,
   output logic              hresp
);

   bus_state_t state, next_state;
   logic       state_en;
   logic       rdata_en;                     // Take R data into the hold register
   logic       read_err_in;
   logic       read_err;                     // R came back with error, one cycle
   logic       hresp_q;
   logic       hready_q;
   logic       trans_act;                    // NONSEQ on the bus for this slave

   assign trans_act = hsel & htrans[1];

   // ********************
   // State machine
   // ********************
   always_comb begin
      next_state  = IDLE;
      state_en    = 1'b0;
      rdata_en    = 1'b0;
      read_err_in = 1'b0;
      cmd_load    = 1'b0;
      case (state)
         IDLE: begin
            next_state = hwrite ? WR : RD;
            state_en   = hready & trans_act;    // Only leave on a real transfer
         end
         WR: begin
            // Next address phase decides the following state
            if (hresp | (htrans == HTRANS_IDLE) | ~hsel) begin
               next_state = IDLE;
            end else begin
               next_state = hwrite ? WR : RD;
            end
            state_en = ~cmd_full | hresp;        // Stall while buffer busy
            // No load on error or while the master is BUSY with its data
            cmd_load = ~cmd_full & ~(hresp | ((htrans == HTRANS_BUSY) & hsel));
         end
         RD: begin
            next_state = hresp ? IDLE : PEND;
            state_en   = ~cmd_full | hresp;
            cmd_load   = ~cmd_full & ~hresp;     // Read goes out unless it failed
         end
         PEND: begin
            next_state  = IDLE;                 // Present data next cycle
            state_en    = rvalid & ~cmd_write;
            rdata_en    = state_en;
            read_err_in = state_en & (|rresp);  // Any non-OKAY response
         end
         default: begin
            next_state = IDLE;
            state_en   = 1'b1;
         end
      endcase
   end

   always_ff @(posedge ahb_clk) begin
      if (rst) begin
         state <= IDLE;
      end else if (state_en) begin
         state <= next_state;
      end
   end

   // ********************
   // AHB response
   // ********************
   // Second error cycle raises HREADYOUT, otherwise stall on busy buffer or open read
   always_comb begin
      if (hresp) begin
         hreadyout = hresp_q & ~hready_q;
      end else begin
         hreadyout = (~cmd_full | (state == IDLE)) &
                     ~((state == RD) | (state == PEND));
      end
   end

   assign hready       = hreadyout & hreadyin;
   assign addr_capture = hready & trans_act;   // Address phase accepted

   // Check error, read error, then hold for the second cycle
   assign hresp = (access_err & (state != IDLE)) |
                  read_err |
                  (hresp_q & ~hready_q);

   always_ff @(posedge ahb_clk) begin
      if (rst) begin
         hresp_q  <= 1'b0;
         hready_q <= 1'b0;
         read_err <= 1'b0;
      end else begin
         hresp_q  <= hresp;
         hready_q <= hready;
         read_err <= read_err_in;
      end
   end

   // Read data hold
   always_ff @(posedge ahb_clk) begin
      if (rdata_en) begin
         hrdata <= rdata;
      end
   end

endmodule

/* verilog/axi_cmd_buffer.sv */
`timescale 1ns/1ps

module axi_cmd_buffer import bridge_pkg::*; (
   input  logic              ahb_clk,
   input  logic              rst,
   input  ahb_req_t          req,          // Captured address phase
   input  logic [DATA_W-1:0] hwdata,
   input  logic              cmd_load,
   input  logic              hresp,        // AHB error, drops a waiting read
   input  logic              awready,
   input  logic              arready,
   output logic              cmd_full,
   output logic              cmd_write,
   output logic              awvalid,
   output logic [ADDR_W-1:0] awaddr,
   output logic [2:0]        awsize,
   output logic              wvalid,
   output logic [DATA_W-1:0] wdata,
   output logic [STRB_W-1:0] wstrb,
   output logic              arvalid,
   output logic [ADDR_W-1:0] araddr,
   output logic [2:0]        arsize
);

   logic              cmd_vld;
   logic              cmd_accept;         // AW/W or AR taken this cycle
   logic              cmd_clear;
   logic [STRB_W-1:0] strb_in;
   logic [ADDR_W-1:0] cmd_addr;
   logic [2:0]        cmd_size;
   logic [STRB_W-1:0] cmd_strb;
   logic [DATA_W-1:0] cmd_wdata;

   // ********************
   // Write strobes
   // ********************
   always_comb begin
      case (req.size)
         HSIZE_BYTE:  strb_in = STRB_W'(1)     << req.addr[OFFS_W-1:0];
         HSIZE_HALF:  strb_in = STRB_W'(2'h3)  << req.addr[OFFS_W-1:0];
         HSIZE_WORD:  strb_in = STRB_W'(4'hf)  << req.addr[OFFS_W-1:0];
         HSIZE_DWORD: strb_in = '1;
         default:     strb_in = '0;
      endcase
   end

   // ********************
   // One entry buffer
   // ********************
   assign cmd_accept = (awvalid & awready) | (arvalid & arready);
   assign cmd_clear  = (cmd_accept & ~cmd_load) | (hresp & ~cmd_write);
   assign cmd_full   = cmd_vld & ~cmd_accept;  // Free again on acceptance

   always_ff @(posedge ahb_clk) begin
      if (rst) begin
         cmd_vld   <= 1'b0;
         cmd_write <= 1'b0;
      end else begin
         if (cmd_clear) begin
            cmd_vld <= 1'b0;
         end else if (cmd_load) begin
            cmd_vld <= 1'b1;                   // Reload in the accept cycle keeps it set
         end
         if (cmd_load) begin
            cmd_write <= req.write;
         end
      end
   end

   // Payload, data phase HWDATA lines up with cmd_load
   always_ff @(posedge ahb_clk) begin
      if (cmd_load) begin
         cmd_addr  <= req.addr;
         cmd_size  <= req.size;
         cmd_strb  <= strb_in;
         cmd_wdata <= hwdata;
      end
   end

   // ********************
   // AXI drive
   // ********************
   assign awvalid = cmd_vld & cmd_write;      // AW and W go together
   assign awaddr  = cmd_addr;
   assign awsize  = cmd_size;
   assign wvalid  = cmd_vld & cmd_write;
   assign wdata   = cmd_wdata;
   assign wstrb   = cmd_strb;
   assign arvalid = cmd_vld & ~cmd_write;
   assign araddr  = cmd_addr;
   assign arsize  = cmd_size;

endmodule

/* verilog/ahb_to_axi_bridge.sv */
`timescale 1ns/1ps

module ahb_to_axi_bridge import bridge_pkg::*; #(
   parameter logic [ADDR_W-1:0] DCCM_BASE    = 32'hf004_0000,
   parameter int                DCCM_SIZE_KB = 64,
   parameter bit                ICCM_EN      = 1'b1,
   parameter logic [ADDR_W-1:0] ICCM_BASE    = 32'hee00_0000,
   parameter int                ICCM_SIZE_KB = 128
) (
   input  logic              ahb_clk,
   input  logic              rst,
   // AHB-Lite slave
   input  logic [ADDR_W-1:0] haddr,
   input  logic [1:0]        htrans,
   input  logic [2:0]        hsize,
   input  logic              hwrite,
   input  logic [DATA_W-1:0] hwdata,
   input  logic              hsel,
   input  logic              hreadyin,
   output logic [DATA_W-1:0] hrdata,
   output logic              hreadyout,
   output logic              hresp,
   // AXI write
   output logic              awvalid,
   input  logic              awready,
   output logic [ADDR_W-1:0] awaddr,
   output logic [2:0]        awsize,
   output logic              wvalid,
   output logic [DATA_W-1:0] wdata,
   output logic [STRB_W-1:0] wstrb,
   // AXI read
   output logic              arvalid,
   input  logic              arready,
   output logic [ADDR_W-1:0] araddr,
   output logic [2:0]        arsize,
   input  logic              rvalid,
   input  logic [DATA_W-1:0] rdata,
   input  logic [1:0]        rresp
);

   ahb_req_t req;                    // Address phase to buffer
   logic     addr_capture;
   logic     access_err;
   logic     cmd_load;
   logic     cmd_full;
   logic     cmd_write;

   // ********************
   // Address phase and checks
   // ********************
   ahb_addr_phase #(
      .DCCM_BASE    (DCCM_BASE),
      .DCCM_SIZE_KB (DCCM_SIZE_KB),
      .ICCM_EN      (ICCM_EN),
      .ICCM_BASE    (ICCM_BASE),
      .ICCM_SIZE_KB (ICCM_SIZE_KB)
   ) ahb_addr_phase_i (.*);

   // Bus FSM keeps HREADY to itself
   ahb_bus_fsm ahb_bus_fsm_i (.*, .hready());

   // AXI side
   axi_cmd_buffer axi_cmd_buffer_i (.*);

endmodule

/* verification/ahb_to_axi_bridge_chk.sv */
`timescale 1ns/1ps

module ahb_to_axi_bridge_chk (
   input logic ahb_clk,
   input logic rst,
   input logic hresp,
   input logic hreadyout,
   input logic awvalid,
   input logic awready,
   input logic wvalid,
   input logic arvalid,
   input logic arready
);

   // ********************
   // AHB error response
   // ********************
   // Second error cycle must follow a first one with HREADYOUT low
   err_two_cycle: assert property (@(posedge ahb_clk) disable iff (rst)
      (hresp && hreadyout) |-> $past(hresp && !hreadyout))
      else $error("AHB error response without first cycle");

   // ********************
   // AXI valid stability
   // ********************
   aw_hold: assert property (@(posedge ahb_clk) disable iff (rst)
      (awvalid && !awready) |=> awvalid)
      else $error("awvalid dropped before awready");

   w_hold: assert property (@(posedge ahb_clk) disable iff (rst)
      (wvalid && !awready) |=> wvalid)             // W is accepted with AW
      else $error("wvalid dropped before awready");

   ar_hold: assert property (@(posedge ahb_clk) disable iff (rst)
      (arvalid && !arready) |=> arvalid)
      else $error("arvalid dropped before arready");

   // An open AR request keeps the AHB data phase waiting
   ar_stall: assert property (@(posedge ahb_clk) disable iff (rst)
      arvalid |-> !hreadyout)
      else $error("hreadyout high while AR request open");

endmodule

/* verification/tb_ahb_to_axi_bridge.sv */
`timescale 1ns/1ps

module tb_ahb_to_axi_bridge import bridge_pkg::*; ();

   localparam int TIMEOUT = 200;             // Cycles per wait loop
   localparam logic [31:0] DCCM = 32'hf004_0000;
   localparam logic [31:0] ICCM = 32'hee00_0000;

   logic              ahb_clk = 1'b0;
   logic              rst;
   logic [ADDR_W-1:0] haddr;
   logic [1:0]        htrans;
   logic [2:0]        hsize;
   logic              hwrite;
   logic [DATA_W-1:0] hwdata;
   logic              hsel;
   logic              hreadyin;
   logic [DATA_W-1:0] hrdata;
   logic              hreadyout;
   logic              hresp;
   logic              awvalid;
   logic              awready;
   logic              wvalid;
   logic              arvalid;
   logic              arready;
   logic              rvalid;
   logic [ADDR_W-1:0] awaddr;
   logic [ADDR_W-1:0] araddr;
   logic [2:0]        awsize;
   logic [2:0]        arsize;
   logic [DATA_W-1:0] wdata;
   logic [DATA_W-1:0] rdata;
   logic [STRB_W-1:0] wstrb;
   logic [1:0]        rresp;

   logic [31:0]       lfsr = 32'hdbf5975c;
   logic              hold_aw;               // Test forces awready low
   logic [DATA_W-1:0] rd_data;               // Next R beat payload
   logic [1:0]        rd_resp;
   logic [ADDR_W-1:0] aw_addr_q[$];
   logic [ADDR_W-1:0] ar_addr_q[$];
   logic [2:0]        aw_size_q[$];
   logic [2:0]        ar_size_q[$];
   logic [DATA_W-1:0] w_data_q[$];
   logic [STRB_W-1:0] w_strb_q[$];

   ahb_to_axi_bridge ahb_to_axi_bridge_i (.*);

   bind ahb_to_axi_bridge ahb_to_axi_bridge_chk chk_i (.*);

   // ********************
   // Helpers
   // ********************
   // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
   function automatic logic [31:0] rand_bits(int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         r    = {r[30:0], fb};
      end
      return r;
   endfunction

   // Byte lanes of a transfer
   function automatic logic [7:0] lane_mask(logic [2:0] size, logic [31:0] addr);
      case (size)
         HSIZE_BYTE: return 8'h01 << addr[2:0];
         HSIZE_HALF: return 8'h03 << addr[2:0];
         HSIZE_WORD: return 8'h0f << addr[2:0];
         default:    return 8'hff;
      endcase
   endfunction

   task automatic report_failure(string what);
      $display("%s", what);
      $display("Verification failed");
      $fatal(1);
   endtask

   task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
      if (got !== exp) begin
         $display("ERROR %s: got %h expected %h", name, got, exp);
         report_failure("Value mismatch, stopping");
      end
   endtask

   // Sample after the falling edge drives have settled
   task automatic wait_hready();
      int n;
      n = 0;
      #1;
      while (hreadyout !== 1'b1) begin
         @(negedge ahb_clk);
         #1;
         if (++n > TIMEOUT) report_failure("Timeout waiting for hreadyout");
      end
   endtask

   task automatic wait_aw_beats(int cnt);
      int n;
      n = 0;
      while (aw_addr_q.size() < cnt) begin
         @(negedge ahb_clk);
         #1;
         if (++n > TIMEOUT) report_failure("Timeout waiting for AXI write beat");
      end
   endtask

   task automatic drive_addr(logic wr, logic [31:0] addr, logic [2:0] size);
      haddr  = addr;
      hsize  = size;
      hwrite = wr;
      htrans = HTRANS_NONSEQ;
      hsel   = 1'b1;
   endtask

   // Single non-pipelined AHB transfer
   task automatic ahb_transfer(logic wr, logic [31:0] addr, logic [2:0] size,
                               logic [63:0] data, logic exp_err, logic [63:0] exp_rd);
      logic first_seen;
      int   n;
      first_seen = 1'b0;
      n = 0;
      @(negedge ahb_clk);
      drive_addr(wr, addr, size);
      wait_hready();                          // Address phase taken at next edge
      @(negedge ahb_clk);
      hwdata = data;
      htrans = HTRANS_IDLE;
      #1;
      while (hreadyout !== 1'b1) begin
         if (hresp) first_seen = 1'b1;        // First error cycle
         @(negedge ahb_clk);
         #1;
         if (++n > TIMEOUT) report_failure("Timeout in AHB data phase");
      end
      check_value("hresp", hresp, exp_err);
      if (exp_err) check_value("hresp_first_cycle", first_seen, 1'b1);
      else if (!wr) check_value("hrdata", hrdata, exp_rd);
   endtask

   // No AXI activity after a failed transfer
   task automatic check_no_axi();
      repeat (4) begin
         @(negedge ahb_clk);
         check_value("awvalid", awvalid, 1'b0);
         check_value("wvalid", wvalid, 1'b0);
         check_value("arvalid", arvalid, 1'b0);
      end
      check_value("aw_beats", aw_addr_q.size(), 0);
      check_value("ar_beats", ar_addr_q.size(), 0);
   endtask

   task automatic check_aw(logic [31:0] addr, logic [2:0] size, logic [63:0] data);
      check_value("awaddr", aw_addr_q.pop_front(), addr);
      check_value("awsize", aw_size_q.pop_front(), size);
      check_value("wdata", w_data_q.pop_front(), data);
      check_value("wstrb", w_strb_q.pop_front(), lane_mask(size, addr));
   endtask

   // ********************
   // Clock, reset, AXI slave
   // ********************
   initial begin
      forever #5 ahb_clk = ~ahb_clk;
   end

   // Random ready and R delays of 0 to 3 cycles
   initial begin
      int aw_wait;
      int ar_wait;
      int r_wait;
      aw_wait = -1;
      ar_wait = -1;
      r_wait  = 0;
      forever begin
         @(negedge ahb_clk);
         awready = 1'b0;
         arready = 1'b0;
         rvalid  = 1'b0;
         if (awvalid && !hold_aw) begin
            if (aw_wait < 0) aw_wait = rand_bits(2);
            if (aw_wait == 0) begin
               check_value("wvalid", wvalid, 1'b1);   // W rides with AW
               awready = 1'b1;                // Handshake at next rising edge
               aw_addr_q.push_back(awaddr);
               aw_size_q.push_back(awsize);
               w_data_q.push_back(wdata);
               w_strb_q.push_back(wstrb);
            end
            aw_wait--;
         end
         if (r_wait > 0) begin
            r_wait--;
            if (r_wait == 0) begin
               rvalid = 1'b1;
               rdata  = rd_data;
               rresp  = rd_resp;
            end
         end else if (arvalid) begin
            if (ar_wait < 0) ar_wait = rand_bits(2);
            if (ar_wait == 0) begin
               arready = 1'b1;
               ar_addr_q.push_back(araddr);
               ar_size_q.push_back(arsize);
               r_wait = rand_bits(2) + 1;      // R strictly after AR
            end
            ar_wait--;
         end
      end
   end

   // ********************
   // Directed tests
   // ********************
   task automatic test_writes();
      logic [31:0] addr[6] = '{DCCM, DCCM + 4, DCCM + 32'h10c, DCCM + 8,
                               DCCM + 32'h1000, ICCM + 32'h24};
      logic [2:0]  size[6] = '{HSIZE_WORD, HSIZE_WORD, HSIZE_WORD, HSIZE_DWORD,
                               HSIZE_DWORD, HSIZE_WORD};
      logic [63:0] data;
      for (int i = 0; i < 6; i++) begin
         data = {rand_bits(32), rand_bits(32)};
         ahb_transfer(1'b1, addr[i], size[i], data, 1'b0, '0);
         wait_aw_beats(1);
         check_aw(addr[i], size[i], data);
      end
   endtask

   task automatic test_reads();
      rd_data = {rand_bits(32), rand_bits(32)};
      ahb_transfer(1'b0, ICCM + 32'h104, HSIZE_WORD, '0, 1'b0, rd_data);
      check_value("araddr", ar_addr_q.pop_front(), ICCM + 32'h104);
      check_value("arsize", ar_size_q.pop_front(), HSIZE_WORD);
      rd_data = {rand_bits(32), rand_bits(32)};
      ahb_transfer(1'b0, DCCM + 32'h208, HSIZE_DWORD, '0, 1'b0, rd_data);
      check_value("araddr", ar_addr_q.pop_front(), DCCM + 32'h208);
      check_value("arsize", ar_size_q.pop_front(), HSIZE_DWORD);
   endtask

   task automatic test_access_errors();
      ahb_transfer(1'b0, 32'h1000_0000, HSIZE_WORD, '0, 1'b1, '0);    // Unmapped
      check_no_axi();
      ahb_transfer(1'b0, DCCM + 1, HSIZE_HALF, '0, 1'b1, '0);         // Odd half
      check_no_axi();
      ahb_transfer(1'b1, DCCM + 6, HSIZE_WORD, 64'h1, 1'b1, '0);      // Word off by 2
      check_no_axi();
      ahb_transfer(1'b1, ICCM + 32'h10, HSIZE_BYTE, 64'h2, 1'b1, '0); // ICCM byte
      check_no_axi();
   endtask

   task automatic test_read_error();
      rd_resp = 2'b10;                         // SLVERR
      ahb_transfer(1'b0, DCCM + 32'h40, HSIZE_WORD, '0, 1'b1, '0);
      rd_resp = 2'b00;
      check_value("araddr", ar_addr_q.pop_front(), DCCM + 32'h40);
      void'(ar_size_q.pop_front());
   endtask

   // Pipelined writes against a stalled AW channel
   task automatic test_back_to_back();
      logic [31:0] addr[3] = '{DCCM + 32'h80, DCCM + 32'h88, DCCM + 32'h94};
      logic [2:0]  size[3] = '{HSIZE_DWORD, HSIZE_DWORD, HSIZE_WORD};
      logic [63:0] data[3];
      for (int i = 0; i < 3; i++) data[i] = {rand_bits(32), rand_bits(32)};
      hold_aw = 1'b1;
      fork
         begin
            @(negedge ahb_clk);
            drive_addr(1'b1, addr[0], size[0]);
            wait_hready();
            for (int i = 0; i < 3; i++) begin
               @(negedge ahb_clk);
               hwdata = data[i];
               if (i < 2) drive_addr(1'b1, addr[i+1], size[i+1]);
               else htrans = HTRANS_IDLE;
               wait_hready();                  // Stalls while buffer is full
               check_value("hresp", hresp, 1'b0);
            end
         end
         begin
            repeat (6) @(negedge ahb_clk);
            #1;
            check_value("hreadyout_stall", hreadyout, 1'b0);
            hold_aw = 1'b0;
         end
      join
      wait_aw_beats(3);
      for (int i = 0; i < 3; i++) check_aw(addr[i], size[i], data[i]);
   endtask

   // ********************
   // Main sequence
   // ********************
   initial begin
      rst = 1'b1;
      haddr = '0;
      htrans = HTRANS_IDLE;
      hsize = HSIZE_WORD;
      hwrite = 1'b0;
      hwdata = '0;
      hsel = 1'b0;
      hreadyin = 1'b1;
      awready = 1'b0;
      arready = 1'b0;
      rvalid = 1'b0;
      rdata = '0;
      rresp = 2'b00;
      hold_aw = 1'b0;
      rd_data = '0;
      rd_resp = 2'b00;
      repeat (5) @(negedge ahb_clk);
      rst = 1'b0;
      #1;
      check_value("hreadyout", hreadyout, 1'b1);
      check_value("hresp", hresp, 1'b0);
      check_value("awvalid", awvalid, 1'b0);
      check_value("wvalid", wvalid, 1'b0);
      check_value("arvalid", arvalid, 1'b0);
      test_writes();
      test_reads();
      test_access_errors();
      test_read_error();
      test_back_to_back();
      repeat (3) @(negedge ahb_clk);
      $display("Verification passed");
      $finish;
   end

endmodule

/* project.f */
common/bridge_pkg.sv
ahb_slave/ahb_addr_phase.sv
ahb_slave/ahb_bus_fsm.sv
verilog/axi_cmd_buffer.sv
verilog/ahb_to_axi_bridge.sv
verification/ahb_to_axi_bridge_chk.sv
verification/tb_ahb_to_axi_bridge.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f project.f \
   --top-module tb_ahb_to_axi_bridge -o tb_sim > build.log 2>&1 \
   || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "Verification failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Verification passed" sim.log || { echo "Simulation incomplete"; exit 1; }
echo "Simulation PASSED"
